/* io_sub_cfg.svh */
`ifndef IO_SUB_CFG_SVH
`define IO_SUB_CFG_SVH

// Processor I/O bus widths
`define IO_ADDR_W 32
`define IO_DATA_W 32

// Board output widths
`define RED_LED_W 18
`define GREEN_LED_W 9
`define HEX_W 7

// Register map, byte addresses on the I/O bus
`define ADDR_RED_LED 32'h0000_0000
`define ADDR_GREEN_LED 32'h0000_0004
`define ADDR_HEX0 32'h0000_0008
`define ADDR_HEX1 32'h0000_000c
`define ADDR_HEX2 32'h0000_0010
`define ADDR_HEX3 32'h0000_0014
`define ADDR_UART_TX 32'h0000_0018
`define ADDR_UART_RX 32'h0000_001c
`define ADDR_TIMER 32'h0000_0024
`define ADDR_FB_BASE 32'h0000_0028
`define ADDR_FRAME 32'h0000_002c

// Segments are active low, so all ones is a dark digit
`define HEX_BLANK 7'b1111111

// Clocks per serial bit, short for simulation
`define DEFAULT_BAUD_DIVIDE 8

`endif

/* io_sub_pkg.sv */
`include "io_sub_cfg.svh"

package io_sub_pkg;
	// Processor side bus words
	typedef logic [`IO_ADDR_W-1:0] io_addr_t;
	typedef logic [`IO_DATA_W-1:0] io_data_t;

	// Board output registers
	typedef logic [`RED_LED_W-1:0] red_led_t;
	typedef logic [`GREEN_LED_W-1:0] green_led_t;
	typedef logic [`HEX_W-1:0] hex_digit_t;

	// Decoded register target, one per mapped address
	typedef enum logic [3:0]
	{
		REG_RED,
		REG_GREEN,
		REG_HEX0,
		REG_HEX1,
		REG_HEX2,
		REG_HEX3,
		REG_UART_TX,
		REG_UART_RX,
		REG_TIMER,
		REG_FB_BASE,
		REG_FRAME,
		REG_NONE
	} io_reg_t;

	// Serial transmitter states
	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;
endpackage

/* io_req_if.sv */
`timescale 1ns/1ps

// Decoded I/O request, one pipeline stage after the processor strobes
interface io_req_if;
	import io_sub_pkg::*;

	// Single-cycle write strobe
	logic wr;

	// Single-cycle read strobe
	logic rd;

	// Target register, REG_NONE for unmapped addresses
	io_reg_t sel;

	// Write payload, full bus width
	io_data_t wdata;

	// Decoder side
	modport source(
		output wr,
		output rd,
		output sel,
		output wdata);

	// Register blocks, transmitter and read path
	modport sink(
		input wr,
		input rd,
		input sel,
		input wdata);
endinterface

/* io_decode.sv */
`timescale 1ns/1ps
`include "io_sub_cfg.svh"

module io_decode(
	input clk,
	input reset,
	input write_en,
	input read_en,
	input io_sub_pkg::io_addr_t address,
	input io_sub_pkg::io_data_t write_data,
	io_req_if.source req);

	import io_sub_pkg::*;

	io_reg_t addr_sel;

	// Address to register target
	always_comb
	begin
		case (address)
			`ADDR_RED_LED: addr_sel = REG_RED;
			`ADDR_GREEN_LED: addr_sel = REG_GREEN;
			`ADDR_HEX0: addr_sel = REG_HEX0;
			`ADDR_HEX1: addr_sel = REG_HEX1;
			`ADDR_HEX2: addr_sel = REG_HEX2;
			`ADDR_HEX3: addr_sel = REG_HEX3;
			`ADDR_UART_TX: addr_sel = REG_UART_TX;
			`ADDR_UART_RX: addr_sel = REG_UART_RX;
			`ADDR_TIMER: addr_sel = REG_TIMER;
			`ADDR_FB_BASE: addr_sel = REG_FB_BASE;
			`ADDR_FRAME: addr_sel = REG_FRAME;
			// Holes in the map write nothing and read zero
			default: addr_sel = REG_NONE;
		endcase
	end

	// Strobes and select, one register stage
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			req.wr <= 1'b0;
			req.rd <= 1'b0;
			req.sel <= REG_NONE;
		end
		else
		begin
			req.wr <= write_en;
			req.rd <= read_en;
			// Select follows the address every cycle, the read path depends on it
			req.sel <= addr_sel;
		end
	end

	// Payload, aligned with the strobes
	always_ff @(posedge clk)
	begin
		req.wdata <= write_data;
	end

	// Processor issues at most one access per cycle
	wr_rd_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(req.wr && req.rd))
		else $error("io_decode: write and read strobes high together");
endmodule

/* display_regs.sv */
`timescale 1ns/1ps
`include "io_sub_cfg.svh"

module display_regs(
	input clk,
	input reset,
	io_req_if.sink req,
	output io_sub_pkg::red_led_t red_led,
	output io_sub_pkg::green_led_t green_led,
	output io_sub_pkg::hex_digit_t hex0,
	output io_sub_pkg::hex_digit_t hex1,
	output io_sub_pkg::hex_digit_t hex2,
	output io_sub_pkg::hex_digit_t hex3,
	output io_sub_pkg::io_data_t fb_base,
	output logic fb_base_update);

	import io_sub_pkg::*;

	// LED and digit registers
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			red_led <= '0;
			green_led <= '0;
			// Digits start dark
			hex0 <= `HEX_BLANK;
			hex1 <= `HEX_BLANK;
			hex2 <= `HEX_BLANK;
			hex3 <= `HEX_BLANK;
		end
		else if (req.wr)
		begin
			// Low bits only, upper write data ignored
			case (req.sel)
				REG_RED: red_led <= req.wdata[`RED_LED_W-1:0];
				REG_GREEN: green_led <= req.wdata[`GREEN_LED_W-1:0];
				REG_HEX0: hex0 <= req.wdata[`HEX_W-1:0];
				REG_HEX1: hex1 <= req.wdata[`HEX_W-1:0];
				REG_HEX2: hex2 <= req.wdata[`HEX_W-1:0];
				REG_HEX3: hex3 <= req.wdata[`HEX_W-1:0];
				default:
				begin
					// Other targets live in other blocks
				end
			endcase
		end
	end

	// Framebuffer base for the display controller
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			fb_base <= '0;
			fb_base_update <= 1'b0;
		end
		else
		begin
			// Pulse lines up with the new base value
			fb_base_update <= req.wr && req.sel == REG_FB_BASE;
			if (req.wr && req.sel == REG_FB_BASE)
				fb_base <= req.wdata;
		end
	end

	// Display controller latches on a single-cycle pulse
	fb_update_single: assert property (@(posedge clk) disable iff (reset)
		fb_base_update |=> !fb_base_update)
		else $error("display_regs: fb_base_update high for two cycles");
endmodule

/* serial_tx.sv */
`timescale 1ns/1ps
`include "io_sub_cfg.svh"

module serial_tx
	#(parameter BAUD_DIVIDE = `DEFAULT_BAUD_DIVIDE)
	(input clk,
	input reset,
	io_req_if.sink req,
	output logic uart_tx,
	output logic busy);

	import io_sub_pkg::*;

	// Baud counter wide enough for the divide and at least one bit
	localparam int CNT_W = (BAUD_DIVIDE > 1) ? $clog2(BAUD_DIVIDE) : 1;
	localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIVIDE - 1);

	tx_state_t state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic bit_end;
	logic start_tx;

	// Last clock of the current bit time
	assign bit_end = baud_cnt == BAUD_LAST;

	// Accepted only when idle so writes while busy are lost
	assign start_tx = req.wr && req.sel == REG_UART_TX && state == TX_IDLE;

	assign busy = state != TX_IDLE;

	// Byte shifter with the next bit always in bit 0
	always_ff @(posedge clk)
	begin
		if (start_tx)
			shift <= req.wdata[7:0];
		else if (bit_end && state != TX_IDLE)
			shift <= {1'b0, shift[7:1]};
	end

	// Framing FSM with registered line output
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			uart_tx <= 1'b1;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					baud_cnt <= '0;
					if (start_tx)
					begin
						state <= TX_START;
						// Start bit
						uart_tx <= 1'b0;
					end
				end

				TX_START:
				begin
					if (bit_end)
					begin
						state <= TX_DATA;
						baud_cnt <= '0;
						bit_cnt <= '0;
						// First data bit is the LSB
						uart_tx <= shift[0];
					end
					else
						baud_cnt <= baud_cnt + CNT_W'(1);
				end

				TX_DATA:
				begin
					if (bit_end)
					begin
						baud_cnt <= '0;
						if (bit_cnt == 3'd7)
						begin
							state <= TX_STOP;
							// Stop bit at the idle level
							uart_tx <= 1'b1;
						end
						else
						begin
							bit_cnt <= bit_cnt + 3'd1;
							uart_tx <= shift[0];
						end
					end
					else
						baud_cnt <= baud_cnt + CNT_W'(1);
				end

				TX_STOP:
				begin
					// busy drops as the stop bit ends
					if (bit_end)
					begin
						state <= TX_IDLE;
						baud_cnt <= '0;
					end
					else
						baud_cnt <= baud_cnt + CNT_W'(1);
				end

				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// Line must rest high between frames
	idle_line_high: assert property (@(posedge clk) disable iff (reset)
		state == TX_IDLE |-> uart_tx)
		else $error("serial_tx: uart_tx low while idle");
endmodule

/* io_readback.sv */
`timescale 1ns/1ps

module io_readback(
	input clk,
	input reset,
	io_req_if.sink req,
	input busy,
	input frame_toggle,
	output io_sub_pkg::io_data_t read_data);

	import io_sub_pkg::*;

	io_data_t timer_val;

	// Free-running cycle count that wraps
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			timer_val <= '0;
		else
			timer_val <= timer_val + io_data_t'(1);
	end

	// Registered read mux
	// Tracks the select every cycle without the read strobe
	always_ff @(posedge clk)
	begin
		case (req.sel)
			// Transmitter status in bit 0
			REG_UART_TX: read_data <= io_data_t'(busy);

			// No receiver in this build
			REG_UART_RX: read_data <= '0;

			REG_TIMER: read_data <= timer_val;

			// Level from the display controller sampled as is
			REG_FRAME: read_data <= io_data_t'(frame_toggle);

			// Write-only registers and holes
			default: read_data <= '0;
		endcase
	end
endmodule

/* io_sub_top.sv */
`timescale 1ns/1ps
`include "io_sub_cfg.svh"

module io_sub_top(
	input clk,
	input reset,

	// Processor I/O strobes
	input write_en,
	input read_en,
	input io_sub_pkg::io_addr_t address,
	input io_sub_pkg::io_data_t write_data,
	output io_sub_pkg::io_data_t read_data,

	// Display controller
	input frame_toggle,
	output io_sub_pkg::io_data_t fb_base,
	output logic fb_base_update,

	// Board outputs
	output io_sub_pkg::red_led_t red_led,
	output io_sub_pkg::green_led_t green_led,
	output io_sub_pkg::hex_digit_t hex0,
	output io_sub_pkg::hex_digit_t hex1,
	output io_sub_pkg::hex_digit_t hex2,
	output io_sub_pkg::hex_digit_t hex3,
	output logic uart_tx);

	// Transmitter status for the read path
	logic tx_busy;

	// Decoded request shared by all targets
	io_req_if req();

	io_decode io_decode(
		.clk(clk),
		.reset(reset),
		.write_en(write_en),
		.read_en(read_en),
		.address(address),
		.write_data(write_data),
		.req(req.source));

	display_regs display_regs(
		.clk(clk),
		.reset(reset),
		.req(req.sink),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.fb_base(fb_base),
		.fb_base_update(fb_base_update));

	serial_tx #(.BAUD_DIVIDE(`DEFAULT_BAUD_DIVIDE)) serial_tx(
		.clk(clk),
		.reset(reset),
		.req(req.sink),
		.uart_tx(uart_tx),
		.busy(tx_busy));

	io_readback io_readback(
		.clk(clk),
		.reset(reset),
		.req(req.sink),
		.busy(tx_busy),
		.frame_toggle(frame_toggle),
		.read_data(read_data));
endmodule

/* tb_io_sub.sv */
`timescale 1ns/1ps
`include "io_sub_cfg.svh"

module tb_io_sub;
	import io_sub_pkg::*;

	localparam int BAUD = `DEFAULT_BAUD_DIVIDE;

	// One stimulus step for a write or a read
	typedef struct {
		bit is_write;
		io_addr_t addr;
		io_data_t data;
		io_data_t expected;
		io_data_t mask;
		bit frame;
	} step_t;

	logic clk;
	logic reset;
	logic write_en;
	logic read_en;
	io_addr_t address;
	io_data_t write_data;
	io_data_t read_data;
	logic frame_toggle;
	io_data_t fb_base;
	logic fb_base_update;
	red_led_t red_led;
	green_led_t green_led;
	hex_digit_t hex0;
	hex_digit_t hex1;
	hex_digit_t hex2;
	hex_digit_t hex3;
	logic uart_tx;

	step_t steps[$];
	integer seed;
	int error_count = 0;
	int timeout_count = 0;
	int check_count = 0;
	int update_pulses = 0;
	int fb_writes = 0;

	// Expected register contents
	red_led_t exp_red;
	green_led_t exp_green;
	hex_digit_t exp_hex[4];
	io_data_t exp_fb;

	io_sub_top dut0(
		.clk(clk),
		.reset(reset),
		.write_en(write_en),
		.read_en(read_en),
		.address(address),
		.write_data(write_data),
		.read_data(read_data),
		.frame_toggle(frame_toggle),
		.fb_base(fb_base),
		.fb_base_update(fb_base_update),
		.red_led(red_led),
		.green_led(green_led),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.uart_tx(uart_tx));

	always #5 clk = ~clk;

	// Counts cycles with the base update pulse high
	always @(negedge clk)
	begin
		if (!reset && fb_base_update)
			update_pulses++;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Error: %s got 'h%h expected 'h%h", name, got, expected);
		end
	endtask

	task automatic add_write(input io_addr_t a, input io_data_t d, input io_data_t m);
		steps.push_back('{1'b1, a, d, d, m, 1'b0});
	endtask

	task automatic add_read(input io_addr_t a, input io_data_t e, input bit f);
		steps.push_back('{1'b0, a, '0, e, 32'hffff_ffff, f});
	endtask

	// Board output that a write to this address lands on
	function automatic io_data_t output_at(input io_addr_t a);
		case (a)
			`ADDR_RED_LED: return io_data_t'(red_led);
			`ADDR_GREEN_LED: return io_data_t'(green_led);
			`ADDR_HEX0: return io_data_t'(hex0);
			`ADDR_HEX1: return io_data_t'(hex1);
			`ADDR_HEX2: return io_data_t'(hex2);
			`ADDR_HEX3: return io_data_t'(hex3);
			`ADDR_FB_BASE: return fb_base;
			default: return '0;
		endcase
	endfunction

	// Register model keeping the low bits per width
	task automatic update_model(input io_addr_t a, input io_data_t d);
		case (a)
			`ADDR_RED_LED: exp_red = d[`RED_LED_W-1:0];
			`ADDR_GREEN_LED: exp_green = d[`GREEN_LED_W-1:0];
			`ADDR_HEX0: exp_hex[0] = d[`HEX_W-1:0];
			`ADDR_HEX1: exp_hex[1] = d[`HEX_W-1:0];
			`ADDR_HEX2: exp_hex[2] = d[`HEX_W-1:0];
			`ADDR_HEX3: exp_hex[3] = d[`HEX_W-1:0];
			`ADDR_FB_BASE:
			begin
				exp_fb = d;
				fb_writes++;
			end
			default:
			begin
				// Holes change nothing
			end
		endcase
	endtask

	task automatic check_outputs();
		check_value("red_led", 32'(red_led), 32'(exp_red));
		check_value("green_led", 32'(green_led), 32'(exp_green));
		check_value("hex0", 32'(hex0), 32'(exp_hex[0]));
		check_value("hex1", 32'(hex1), 32'(exp_hex[1]));
		check_value("hex2", 32'(hex2), 32'(exp_hex[2]));
		check_value("hex3", 32'(hex3), 32'(exp_hex[3]));
		check_value("fb_base", fb_base, exp_fb);
	endtask

	// One-cycle strobe with the result due two edges later
	task automatic apply_step(input step_t s);
		io_data_t seen;
		@(posedge clk);
		write_en <= s.is_write;
		read_en <= !s.is_write;
		address <= s.addr;
		write_data <= s.data;
		frame_toggle <= s.frame;
		@(posedge clk);
		write_en <= 1'b0;
		read_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		if (s.is_write)
			update_model(s.addr, s.data);
		seen = s.is_write ? output_at(s.addr) : read_data;
		// Holes have no output of their own
		if (s.mask != '0)
			check_value(s.is_write ? "written output" : "read_data", seen & s.mask,
				s.expected & s.mask);
		check_value("fb_base_update", 32'(fb_base_update),
			32'(s.is_write && s.addr == `ADDR_FB_BASE));
		check_outputs();
	endtask

	// Two timer reads k edges apart
	task automatic timer_gap(input int k);
		io_data_t first;
		@(posedge clk);
		read_en <= 1'b1;
		address <= `ADDR_TIMER;
		@(posedge clk);
		read_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		first = read_data;
		repeat (k - 2) @(posedge clk);
		read_en <= 1'b1;
		@(posedge clk);
		read_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("timer delta", read_data - first, k);
	endtask

	// Processor side of a transmit with an optional second byte while busy
	task automatic send_byte(input logic [7:0] b, input bit drop_second);
		int wait_cycles;
		@(posedge clk);
		write_en <= 1'b1;
		address <= `ADDR_UART_TX;
		write_data <= {24'hc3a5f0, b};
		@(posedge clk);
		write_en <= 1'b0;
		read_en <= 1'b1;
		@(posedge clk);
		read_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("read_data busy", read_data, 1);
		// Cycles counted from this first busy read
		wait_cycles = 0;
		if (drop_second)
		begin
			@(posedge clk);
			write_en <= 1'b1;
			write_data <= {24'h0, ~b};
			@(posedge clk);
			write_en <= 1'b0;
			@(negedge clk);
			wait_cycles = 2;
		end
		// read_data follows busy while the address stays on the status register
		while (read_data !== '0 && wait_cycles < 20 * BAUD)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		// Busy lasts ten bit times of BAUD clocks each
		if (read_data !== '0)
		begin
			timeout_count++;
			$display("Timeout: transmitter stayed busy");
		end
		else
			check_value("busy cycles", wait_cycles, 10 * BAUD);
	endtask

	// Line monitor sampling mid-bit
	task automatic receive_frame(output logic [7:0] got);
		int wait_cycles;
		int i;
		bit low_seen;
		got = 8'h00;
		wait_cycles = 0;
		@(negedge clk);
		while (uart_tx !== 1'b0 && wait_cycles < 4 * BAUD)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (uart_tx !== 1'b0)
		begin
			timeout_count++;
			$display("Timeout: no start bit on uart_tx");
		end
		else
		begin
			repeat (BAUD / 2) @(negedge clk);
			check_value("uart_tx start bit", 32'(uart_tx), 0);
			for (i = 0; i < 8; i++)
			begin
				repeat (BAUD) @(negedge clk);
				got[i] = uart_tx;
			end
			repeat (BAUD) @(negedge clk);
			check_value("uart_tx stop bit", 32'(uart_tx), 1);
			// A dropped byte would start a second frame here
			low_seen = 1'b0;
			for (i = 0; i < 3 * BAUD; i++)
			begin
				@(negedge clk);
				if (uart_tx !== 1'b1)
					low_seen = 1'b1;
			end
			check_value("uart_tx idle after frame", 32'(low_seen), 0);
		end
	endtask

	task automatic serial_test(input bit drop_second);
		logic [7:0] sent;
		logic [7:0] got;
		sent = 8'($random(seed));
		fork
			send_byte(sent, drop_second);
			receive_frame(got);
		join
		check_value("uart_tx byte", 32'(got), 32'(sent));
	endtask

	initial
	begin
		seed = 32'h1e63_7cf8;
		clk = 1'b0;
		reset = 1'b1;
		write_en = 1'b0;
		read_en = 1'b0;
		address = '0;
		write_data = '0;
		frame_toggle = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		// Reset state
		exp_red = '0;
		exp_green = '0;
		exp_hex = '{4{`HEX_BLANK}};
		exp_fb = '0;
		check_outputs();
		check_value("uart_tx", 32'(uart_tx), 1);
		check_value("fb_base_update", 32'(fb_base_update), 0);

		// Display writes, holes and framebuffer base
		add_write(`ADDR_RED_LED, $random(seed), (32'h1 << `RED_LED_W) - 1);
		add_write(`ADDR_GREEN_LED, $random(seed), (32'h1 << `GREEN_LED_W) - 1);
		add_write(`ADDR_HEX0, $random(seed), (32'h1 << `HEX_W) - 1);
		add_write(`ADDR_HEX1, $random(seed), (32'h1 << `HEX_W) - 1);
		add_write(`ADDR_HEX2, $random(seed), (32'h1 << `HEX_W) - 1);
		add_write(`ADDR_HEX3, $random(seed), (32'h1 << `HEX_W) - 1);
		add_write(32'h0000_0020, $random(seed), '0);
		add_write(32'h0000_0100, $random(seed), '0);
		add_write(`ADDR_FB_BASE, $random(seed), 32'hffff_ffff);
		add_write(`ADDR_RED_LED, $random(seed), (32'h1 << `RED_LED_W) - 1);
		add_write(`ADDR_FB_BASE, $random(seed), 32'hffff_ffff);
		// Read-back of levels, holes and write-only registers
		add_read(`ADDR_FRAME, 1, 1'b1);
		add_read(`ADDR_FRAME, 0, 1'b0);
		add_read(`ADDR_UART_RX, 0, 1'b1);
		add_read(32'h0000_0020, 0, 1'b1);
		add_read(32'h0000_0034, 0, 1'b0);
		add_read(`ADDR_RED_LED, 0, 1'b0);
		add_read(`ADDR_UART_TX, 0, 1'b0);
		foreach (steps[i])
			apply_step(steps[i]);

		timer_gap(3);
		timer_gap(3 + ($unsigned($random(seed)) % 20));
		serial_test(1'b0);
		serial_test(1'b1);
		check_value("fb_base_update pulse count", update_pulses, fb_writes);

		$display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end
endmodule

/* io_sub.f */
+incdir+.
io_sub_pkg.sv
io_req_if.sv
io_decode.sv
display_regs.sv
serial_tx.sv
io_readback.sv
io_sub_top.sv
tb_io_sub.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST ?= io_sub.f
TOP ?= tb_io_sub
RTL_TOP ?= io_sub_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
